/* hdl/mem_share_pkg.sv */
// Shared sizes for the four-peer shared-memory subsystem.
// Peer count, grant index width, memory geometry and the
// state codes of the per-peer handshake port.

package mem_share_pkg;

  // Number of peer clients that share the memory.
  localparam int unsigned NumPeers = 4;

  // Width of a binary grant index, enough to name every peer.
  localparam int unsigned PeerIdxWidth = 2;

  // Word address width and the matching number of words.
  localparam int unsigned MemAddrWidth = 4;
  localparam int unsigned MemDepth = 16;

  // Width of one memory word.
  localparam int unsigned DataWidth = 16;

  // State codes of the req/ack port FSM.
  // Idle waits for a request, wait holds it until the access is captured,
  // and acked holds the ack until the peer lets go of its request.
  localparam logic [1:0] PortIdle = 2'd0;
  localparam logic [1:0] PortWait = 2'd1;
  localparam logic [1:0] PortAcked = 2'd2;

endpackage : mem_share_pkg

/* hdl/mem_share_top.sv */
// Shared-memory subsystem top level.
// Per-peer req/ack ports, the round-robin arbiter, the grant-steered
// memory bus, the grant checker, the memory and the sticky error flag.

module mem_share_top (
  input  logic                                                        clk_i,
  input  logic                                                        rst_n_i,
  input  logic [mem_share_pkg::NumPeers-1:0]                          req_i,
  input  logic [mem_share_pkg::NumPeers-1:0]                          we_i,
  input  logic [mem_share_pkg::NumPeers*mem_share_pkg::MemAddrWidth-1:0] addr_i,
  input  logic [mem_share_pkg::NumPeers*mem_share_pkg::DataWidth-1:0] wdata_i,
  output logic [mem_share_pkg::NumPeers-1:0]                          ack_o,
  output logic [mem_share_pkg::NumPeers*mem_share_pkg::DataWidth-1:0] rdata_o,
  output logic                                                        fatal_err_o
);

  import mem_share_pkg::*;

  logic [NumPeers-1:0]     pend;
  logic [NumPeers-1:0]     gnt;
  logic [PeerIdxWidth-1:0] gnt_idx;
  logic                    gnt_valid;
  logic                    mem_we;
  logic [MemAddrWidth-1:0] mem_addr;
  logic [DataWidth-1:0]    mem_wdata;
  logic [DataWidth-1:0]    mem_rdata;
  logic                    oh_err;

  ////////////////////////////////////////////////////////////////////////////
  // Peer ports
  ////////////////////////////////////////////////////////////////////////////

  // All ports see the same read data; each takes it only after its own grant.
  for (genvar p = 0; p < NumPeers; p++) begin : gen_port
    req_ack_port i_req_ack_port (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req_i       (req_i[p]),
      .gnt_i       (gnt[p]),
      .mem_rdata_i (mem_rdata),
      .pend_o      (pend[p]),
      .ack_o       (ack_o[p]),
      .rdata_o     (rdata_o[p*DataWidth +: DataWidth])
    );
  end : gen_port

  rr_arbiter i_rr_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .pend_i      (pend),
    .gnt_o       (gnt),
    .gnt_idx_o   (gnt_idx),
    .gnt_valid_o (gnt_valid)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Memory bus
  ////////////////////////////////////////////////////////////////////////////

  // The binary index steers the granted peer's request onto the memory.
  // Without a valid grant the memory only does a harmless read.
  assign mem_addr = addr_i[gnt_idx*MemAddrWidth +: MemAddrWidth];
  assign mem_wdata = wdata_i[gnt_idx*DataWidth +: DataWidth];
  assign mem_we = gnt_valid && we_i[gnt_idx];

  shared_sram i_shared_sram (
    .clk_i   (clk_i),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

  // The vector, the index and the flag must tell the same story.
  onehot_check i_onehot_check (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .oh_i    (gnt),
    .idx_i   (gnt_idx),
    .en_i    (gnt_valid),
    .err_o   (oh_err)
  );

  // Once set, the fatal flag stays up until reset.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fatal_err_o <= 1'b0;
    end else if (oh_err) begin
      fatal_err_o <= 1'b1;
    end
  end

endmodule : mem_share_top

/* hdl/onehot_check.sv */
// Grant vector checker.
// Flags a vector with more than one bit set, a vector whose OR
// disagrees with the valid flag, or a set bit away from the index.
// Built from explicit binary trees to keep the logic depth short.

module onehot_check (
  // The checker itself is combinational; clock and reset feed the assertions.
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic [mem_share_pkg::NumPeers-1:0]      oh_i,
  input  logic [mem_share_pkg::PeerIdxWidth-1:0]  idx_i,
  input  logic                                    en_i,
  output logic                                    err_o
);

  import mem_share_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Binary trees
  ////////////////////////////////////////////////////////////////////////////

  // A full tree with PeerIdxWidth levels above the leaves holds
  // 2**(PeerIdxWidth+1)-1 nodes. Node 0 is the root.
  // On level l the first node sits at 2**l-1, and the children of
  // node (2**l-1+k) sit at 2**(l+1)-1+2k and the one after it.
  logic [2**(PeerIdxWidth+1)-2:0] or_tree;
  // The AND tree follows idx_i down from the root, so its root is the
  // vector bit that the index points at.
  logic [2**(PeerIdxWidth+1)-2:0] and_tree;
  // The collision tree goes high where both halves of a subtree hold a set bit.
  logic [2**(PeerIdxWidth+1)-2:0] err_tree;

  for (genvar level = 0; level <= PeerIdxWidth; level++) begin : gen_tree
    for (genvar offset = 0; offset < 2**level; offset++) begin : gen_level
      if (level == PeerIdxWidth) begin : gen_leaf
        // Leaves past the last peer are tied off.
        if (offset < NumPeers) begin : gen_assign
          assign or_tree[2**level-1+offset]  = oh_i[offset];
          assign and_tree[2**level-1+offset] = oh_i[offset];
        end else begin : gen_tie_off
          assign or_tree[2**level-1+offset]  = 1'b0;
          assign and_tree[2**level-1+offset] = 1'b0;
        end
        assign err_tree[2**level-1+offset] = 1'b0;
      end else begin : gen_node
        assign or_tree[2**level-1+offset] = or_tree[2**(level+1)-1+2*offset] ||
                                            or_tree[2**(level+1)+2*offset];
        // The index bit for this level picks the lower or the upper child.
        assign and_tree[2**level-1+offset] =
          (!idx_i[PeerIdxWidth-1-level] && and_tree[2**(level+1)-1+2*offset]) ||
          (idx_i[PeerIdxWidth-1-level] && and_tree[2**(level+1)+2*offset]);
        assign err_tree[2**level-1+offset] =
          (or_tree[2**(level+1)-1+2*offset] && or_tree[2**(level+1)+2*offset]) ||
          err_tree[2**(level+1)-1+2*offset] || err_tree[2**(level+1)+2*offset];
      end
    end : gen_level
  end : gen_tree

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  logic oh0_err;
  logic enable_err;
  logic addr_err;

  // More than one bit set anywhere in the vector.
  assign oh0_err = err_tree[0];
  // A grant must show up exactly when the valid flag is high.
  assign enable_err = or_tree[0] ^ en_i;
  // With one bit set, the steered AND must land on it.
  assign addr_err = or_tree[0] ^ and_tree[0];

  assign err_o = oh0_err || enable_err || addr_err;

  // The trees must catch every bad vector that a plain reduction would.
  onehot0_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$onehot0(oh_i) |-> err_o);
  enable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ((|oh_i) != en_i) |-> err_o);
  index_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (oh_i[idx_i] != (|oh_i)) |-> err_o);

endmodule : onehot_check

/* hdl/req_ack_port.sv */
// Four-phase slave port for one peer.
// Turns a peer request into a pending flag for the arbiter,
// captures read data after the grant and runs the ack handshake.

module req_ack_port (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 req_i,
  input  logic                                 gnt_i,
  input  logic [mem_share_pkg::DataWidth-1:0]  mem_rdata_i,
  output logic                                 pend_o,
  output logic                                 ack_o,
  output logic [mem_share_pkg::DataWidth-1:0]  rdata_o
);

  import mem_share_pkg::*;

  logic [1:0] state_q;
  // High in the cycle after the grant, when memory read data is valid.
  logic       cap_q;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= PortIdle;
      pend_o <= 1'b0;
      cap_q <= 1'b0;
    end else begin
      cap_q <= gnt_i;
      case (state_q)
        // Ack is low here, so a request seen now is a fresh one.
        PortIdle: begin
          if (req_i) begin
            state_q <= PortWait;
            pend_o <= 1'b1;
          end
        end
        // Pending drops at the edge that ends the grant.
        // The ack follows one edge later, together with the read data.
        PortWait: begin
          if (gnt_i) begin
            pend_o <= 1'b0;
          end
          if (cap_q) begin
            state_q <= PortAcked;
          end
        end
        // Stay here until the peer drops its request.
        PortAcked: begin
          if (!req_i) begin
            state_q <= PortIdle;
          end
        end
        default: state_q <= PortIdle;
      endcase
    end
  end

  assign ack_o = (state_q == PortAcked);

  // Read data is held until the next access of this peer.
  always_ff @(posedge clk_i) begin
    if (cap_q) begin
      rdata_o <= mem_rdata_i;
    end
  end

  // The arbiter must only grant a port that has a request pending.
  gnt_pend_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gnt_i |-> pend_o);

endmodule : req_ack_port

/* hdl/rr_arbiter.sv */
// Round-robin arbiter for the shared memory bus.
// Issues registered one-cycle grants as a one-hot vector,
// a binary index and a valid flag.

module rr_arbiter (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic [mem_share_pkg::NumPeers-1:0]      pend_i,
  output logic [mem_share_pkg::NumPeers-1:0]      gnt_o,
  output logic [mem_share_pkg::PeerIdxWidth-1:0]  gnt_idx_o,
  output logic                                    gnt_valid_o
);

  import mem_share_pkg::*;

  // The peer with top priority in the next search.
  // It always sits one past the last winner.
  logic [PeerIdxWidth-1:0] ptr_q;

  logic [NumPeers-1:0]     eligible;
  logic                    win_found;
  logic [PeerIdxWidth-1:0] win_idx;

  // The peer granted right now still shows pend_i during its grant cycle,
  // so it is taken out of the race here.
  assign eligible = pend_i & ~gnt_o;

  ////////////////////////////////////////////////////////////////////////////
  // Priority search
  ////////////////////////////////////////////////////////////////////////////

  // Walk the peers once, starting at the pointer.
  // The index sum wraps on its own since the peer count is a power of two.
  always_comb begin
    logic [PeerIdxWidth-1:0] cand;
    win_found = 1'b0;
    win_idx = '0;
    for (int unsigned i = 0; i < NumPeers; i++) begin
      cand = ptr_q + PeerIdxWidth'(i);
      if (!win_found && eligible[cand]) begin
        win_found = 1'b1;
        win_idx = cand;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Grant registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gnt_o <= '0;
      gnt_idx_o <= '0;
      gnt_valid_o <= 1'b0;
      ptr_q <= '0;
    end else begin
      // Each grant lasts a single cycle unless a new winner follows.
      gnt_valid_o <= win_found;
      gnt_o <= win_found ? (NumPeers'(1) << win_idx) : '0;
      gnt_idx_o <= win_idx;
      // The pointer only moves when a grant is actually issued.
      if (win_found) begin
        ptr_q <= win_idx + 1'b1;
      end
    end
  end

  // A grant always goes to a peer that was pending the cycle before.
  grant_pending_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gnt_valid_o |-> (($past(pend_i) & gnt_o) != '0));

endmodule : rr_arbiter

/* hdl/shared_sram.sv */
// Single-port word memory shared by all peers.
// Synchronous write with a registered read of the old word.

module shared_sram (
  input  logic                                    clk_i,
  input  logic                                    we_i,
  input  logic [mem_share_pkg::MemAddrWidth-1:0]  addr_i,
  input  logic [mem_share_pkg::DataWidth-1:0]     wdata_i,
  output logic [mem_share_pkg::DataWidth-1:0]     rdata_o
);

  import mem_share_pkg::*;

  // One word per address.
  logic [DataWidth-1:0] mem_q [MemDepth];

  ////////////////////////////////////////////////////////////////////////////
  // Access
  ////////////////////////////////////////////////////////////////////////////

  // The write lands at the edge that ends the grant cycle.
  // In the same edge the read register takes the word as it was before,
  // so a write returns the old contents, and a read its current word.
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
    rdata_o <= mem_q[addr_i];
  end

  // The read runs every cycle; only the port that was granted
  // one cycle earlier picks up the result.

endmodule : shared_sram

/* project.f */
hdl/mem_share_pkg.sv
hdl/onehot_check.sv
hdl/rr_arbiter.sv
hdl/req_ack_port.sv
hdl/shared_sram.sv
hdl/mem_share_top.sv
sim/mem_share_checker.sv
sim/tb_mem_share.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and search the log for the pass line.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_mem_share -f project.f -o tb_mem_share \
  && ./obj_dir/tb_mem_share 2>&1 | tee sim.log \
  || { echo "Build or run failed"; exit 1; }
grep -qx "Finished with no errors" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* sim/mem_share_checker.sv */
// Monitor for the shared-memory subsystem.
// Keeps a model of the memory and checks read data, the four-phase
// protocol, round-robin fairness, ack latency, the fatal flag and reset.

module mem_share_checker (
  input  logic                                                          clk_i,
  input  logic                                                          rst_n_i,
  input  logic [mem_share_pkg::NumPeers-1:0]                            req_i,
  input  logic [mem_share_pkg::NumPeers-1:0]                            we_i,
  input  logic [mem_share_pkg::NumPeers*mem_share_pkg::MemAddrWidth-1:0] addr_i,
  input  logic [mem_share_pkg::NumPeers*mem_share_pkg::DataWidth-1:0]   wdata_i,
  input  logic [mem_share_pkg::NumPeers-1:0]                            ack_i,
  input  logic [mem_share_pkg::NumPeers*mem_share_pkg::DataWidth-1:0]   rdata_i,
  input  logic                                                          fatal_err_i,
  output int unsigned                                                   err_cnt_o,
  output int unsigned                                                   check_cnt_o
);

  import mem_share_pkg::*;

  // Ack latency window in cycles, counted from the first cycle of the request.
  localparam int unsigned MinLatency = 4;
  localparam int unsigned MaxLatency = 4 + 2 * (NumPeers - 1);

  // Model memory; words that were never written are not compared.
  logic [DataWidth-1:0] model_mem [MemDepth];
  logic [MemDepth-1:0]  model_valid = '0;
  logic [NumPeers-1:0]  req_q = '0;
  logic [NumPeers-1:0]  ack_q = '0;
  // Peers whose current request has not been acked yet.
  logic [NumPeers-1:0]  waiting = '0;
  logic [NumPeers-1:0]  acked_once = '0;
  logic                 rst_q = 1'b0;
  logic                 fatal_q = 1'b0;
  int unsigned          cycle = 0;
  int unsigned          req_cycle [NumPeers];
  int unsigned          ack_cycle [NumPeers];
  int unsigned          drop_cnt [NumPeers];
  int unsigned          err_cnt = 0;
  int unsigned          check_cnt = 0;

  assign err_cnt_o = err_cnt;
  assign check_cnt_o = check_cnt;

  task automatic flag_error(input string msg);
    $display("%s", msg);
    err_cnt++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks on a rising ack
  ////////////////////////////////////////////////////////////////////////////

  // Acks rise in service order, so the model is updated here.
  task automatic check_ack(input int unsigned p);
    logic [MemAddrWidth-1:0] addr;
    logic [DataWidth-1:0]    rdata;
    int unsigned             lat;
    addr = addr_i[p*MemAddrWidth +: MemAddrWidth];
    rdata = rdata_i[p*DataWidth +: DataWidth];
    lat = cycle - req_cycle[p];
    check_cnt++;
    if (!req_i[p] || !waiting[p]) begin
      flag_error($sformatf("Protocol error at %0t: peer %0d raised ack without a request",
                           $time, p));
    end else if (lat < MinLatency || lat > MaxLatency) begin
      flag_error($sformatf("Latency error at %0t: peer %0d acked after %0d cycles",
                           $time, p, lat));
    end
    // Nobody who waited since before this peer's last ack may be passed over.
    if (acked_once[p]) begin
      for (int unsigned q = 0; q < NumPeers; q++) begin
        if (q != p && waiting[q] && req_cycle[q] < ack_cycle[p]) begin
          flag_error($sformatf("Fairness error at %0t: peer %0d served twice before peer %0d",
                               $time, p, q));
        end
      end
    end
    if (we_i[p]) begin
      model_mem[addr] = wdata_i[p*DataWidth +: DataWidth];
      model_valid[addr] = 1'b1;
    end else if (model_valid[addr] && rdata !== model_mem[addr]) begin
      flag_error($sformatf("Mismatch at %0t: peer %0d addr 0x%0h expected 0x%04h actual 0x%04h",
                           $time, p, addr, model_mem[addr], rdata));
    end
    waiting[p] = 1'b0;
    acked_once[p] = 1'b1;
    ack_cycle[p] = cycle;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Per-cycle checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_cycle();
    cycle++;
    // Acks and the fatal flag stay low in reset and in the first cycle after it.
    if (!rst_n_i || !rst_q) begin
      check_cnt++;
      if (ack_i !== '0 || fatal_err_i !== 1'b0) begin
        flag_error($sformatf("Reset error at %0t: ack or the fatal flag is high around reset",
                             $time));
      end
    end
    if (fatal_err_i && !fatal_q) begin
      flag_error($sformatf("Integrity error at %0t: the fatal error flag went high", $time));
    end
    if (rst_n_i) begin
      for (int unsigned p = 0; p < NumPeers; p++) begin
        if (req_i[p] && !req_q[p]) begin
          req_cycle[p] = cycle;
          waiting[p] = 1'b1;
        end
        if (ack_i[p] && !ack_q[p]) begin
          check_ack(p);
        end
        // The ack may outlive the request by one cycle at most.
        if (ack_i[p] && !req_i[p]) begin
          drop_cnt[p]++;
          if (drop_cnt[p] == 2) begin
            flag_error($sformatf("Protocol error at %0t: peer %0d ack stuck after request fell",
                                 $time, p));
          end
        end else begin
          drop_cnt[p] = 0;
        end
      end
    end
    rst_q = rst_n_i;
    fatal_q = fatal_err_i;
    req_q = req_i;
    ack_q = ack_i;
  endtask

  // Sampled away from the rising edge, where all DUT outputs are settled.
  always @(negedge clk_i) begin
    check_cycle();
  end

endmodule : mem_share_checker

/* sim/tb_mem_share.sv */
// Testbench top for the shared-memory subsystem.
// Clock, reset, seeded random peer drivers, the DUT, the monitor
// and the watchdog.

module tb_mem_share;

  import mem_share_pkg::*;

  localparam int unsigned ClkPeriod = 20;
  localparam int unsigned ResetCycles = 10;
  // Accesses per peer; the second half runs on 4 addresses with short gaps.
  localparam int unsigned NumAccesses = 40;
  localparam int unsigned TimeoutCycles = NumAccesses * NumPeers * 30;

  // Driver phases of one peer.
  localparam logic [1:0] PhaseGap = 2'd0;
  localparam logic [1:0] PhaseReq = 2'd1;
  localparam logic [1:0] PhaseHold = 2'd2;
  localparam logic [1:0] PhaseRelease = 2'd3;

  logic                              clk = 1'b0;
  logic                              rst_n;
  logic [NumPeers-1:0]               req;
  logic [NumPeers-1:0]               we;
  logic [NumPeers*MemAddrWidth-1:0]  addr;
  logic [NumPeers*DataWidth-1:0]     wdata;
  logic [NumPeers-1:0]               ack;
  logic [NumPeers*DataWidth-1:0]     rdata;
  logic                              fatal_err;
  int unsigned                       err_cnt;
  int unsigned                       check_cnt;
  integer                            seed;
  logic [1:0]                        phase [NumPeers];
  logic [2:0]                        gap_cnt [NumPeers];
  logic [1:0]                        hold_cnt [NumPeers];
  int unsigned                       done_cnt [NumPeers];

  always #(ClkPeriod / 2) clk = ~clk;

  mem_share_top i_mem_share_top (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_i       (req),
    .we_i        (we),
    .addr_i      (addr),
    .wdata_i     (wdata),
    .ack_o       (ack),
    .rdata_o     (rdata),
    .fatal_err_o (fatal_err)
  );

  mem_share_checker i_mem_share_checker (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_i       (req),
    .we_i        (we),
    .addr_i      (addr),
    .wdata_i     (wdata),
    .ack_i       (ack),
    .rdata_i     (rdata),
    .fatal_err_i (fatal_err),
    .err_cnt_o   (err_cnt),
    .check_cnt_o (check_cnt)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Peer drivers
  ////////////////////////////////////////////////////////////////////////////

  // One step of every peer's four-phase handshake, called at each rising edge.
  task automatic step_peers();
    logic [31:0] rnd;
    for (int unsigned p = 0; p < NumPeers; p++) begin
      rnd = $random(seed);
      case (phase[p])
        PhaseGap: begin
          if (gap_cnt[p] != 3'd0) begin
            gap_cnt[p] = gap_cnt[p] - 3'd1;
          end else if (done_cnt[p] < NumAccesses) begin
            // The fields stay put until the ack has come back.
            req[p] <= 1'b1;
            we[p] <= rnd[0];
            addr[p*MemAddrWidth +: MemAddrWidth] <= (done_cnt[p] >= NumAccesses / 2) ?
                                                    MemAddrWidth'(rnd[2:1]) : rnd[4:1];
            wdata[p*DataWidth +: DataWidth] <= rnd[31:16];
            phase[p] = PhaseReq;
          end
        end
        PhaseReq: begin
          if (ack[p]) begin
            hold_cnt[p] = rnd[1:0];
            phase[p] = PhaseHold;
          end
        end
        // Keep the request up a little longer to apply back-pressure.
        PhaseHold: begin
          if (hold_cnt[p] != 2'd0) begin
            hold_cnt[p] = hold_cnt[p] - 2'd1;
          end else begin
            req[p] <= 1'b0;
            phase[p] = PhaseRelease;
          end
        end
        default: begin
          // A new request only follows once the ack is seen low.
          if (!ack[p]) begin
            done_cnt[p]++;
            gap_cnt[p] = (done_cnt[p] >= NumAccesses / 2) ? {2'b00, rnd[5]} : rnd[7:5];
            phase[p] = PhaseGap;
          end
        end
      endcase
    end
  endtask

  function automatic logic all_done();
    logic done;
    done = 1'b1;
    for (int unsigned p = 0; p < NumPeers; p++) begin
      if (done_cnt[p] < NumAccesses || phase[p] != PhaseGap) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  initial begin
    seed = 32'hca89_6bb9;
    rst_n <= 1'b0;
    req <= '0;
    we <= '0;
    addr <= '0;
    wdata <= '0;
    for (int unsigned p = 0; p < NumPeers; p++) begin
      phase[p] = PhaseGap;
      gap_cnt[p] = 3'(p);
      hold_cnt[p] = 2'd0;
      done_cnt[p] = 0;
    end
    repeat (ResetCycles) @(posedge clk);
    rst_n <= 1'b1;
    while (!all_done()) begin
      @(posedge clk);
      step_peers();
    end
    repeat (8) @(posedge clk);
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog, sized generously from the number of accesses.
  initial begin
    #((ResetCycles + TimeoutCycles) * ClkPeriod);
    $display("Timeout: the accesses did not complete within %0d cycles", TimeoutCycles);
    $display("Finished with errors");
    $finish;
  end

endmodule : tb_mem_share
